// ==== md_config.svh ====
`ifndef MD_CONFIG_SVH
`define MD_CONFIG_SVH

// operand and result width, fixed by RV32M
`define MD_XLEN     32
// physical register tag from the rename stage
`define MD_PHY_W    8
`define MD_INUM_W   32

// one step per bit, so the counter spans MD_XLEN steps
`define MD_CNT_W    5
`define MD_LATENCY  35  // start edge to done cycle

`endif

// ==== md_pkg.sv ====
`include "md_config.svh"

package md_pkg;

    // funct3 of the M extension
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } md_op_e;

    typedef enum logic [2:0] {
        IDLE = 3'd0,
        PREP = 3'd1,
        RUN  = 3'd2,
        FIX  = 3'd3,
        DONE = 3'd4
    } md_phase_e;

    typedef struct packed {
        md_op_e                 op;
        logic [`MD_XLEN-1:0]    a;
        logic [`MD_XLEN-1:0]    b;
        logic [`MD_PHY_W-1:0]   phy;
        logic [`MD_INUM_W-1:0]  inst_num;
    } md_issue_t;

    typedef struct packed {
        logic [`MD_XLEN-1:0]    data;
        logic [`MD_PHY_W-1:0]   phy;
        logic [`MD_INUM_W-1:0]  inst_num;
    } md_result_t;

    typedef struct packed {
        logic [`MD_XLEN-1:0]    mag_a;
        logic [`MD_XLEN-1:0]    mag_b;
        logic                   is_div;
        logic                   sel_hi;      // high product half or remainder
        logic                   negate;
        logic                   special;
        logic [`MD_XLEN-1:0]    special_val;
    } md_prep_t;

endpackage

// ==== md_control.sv ====
`timescale 1ns/1ns
`include "md_config.svh"

module md_control
    import md_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      flush,
    input  logic      last,
    output md_phase_e phase,
    output logic      busy,
    output logic      done
);

    md_phase_e phase_nx;

    always_comb begin
        phase_nx = phase;
        case (phase)
            IDLE: begin
                if (start) begin
                    phase_nx = PREP;
                end
            end
            PREP: begin
                phase_nx = RUN;     // operands settle in one cycle
            end
            RUN: begin
                if (last) begin
                    phase_nx = FIX;
                end
            end
            FIX: begin
                phase_nx = DONE;
            end
            DONE: begin
                phase_nx = IDLE;
            end
            default: begin
                phase_nx = IDLE;
            end
        endcase

        // exception flush from the core kills whatever is in flight
        if (flush) begin
            phase_nx = IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= IDLE;
        end else begin
            phase <= phase_nx;
        end
    end

    // start is only taken in IDLE, so busy also blocks re-issue
    assign busy = (phase != IDLE);
    assign done = (phase == DONE);    // single cycle, result on the bus

endmodule

// ==== md_step_counter.sv ====
`timescale 1ns/1ns
`include "md_config.svh"

module md_step_counter
    import md_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  md_phase_e phase,
    output logic      last
);

    logic [`MD_CNT_W-1:0] step_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_q <= '0;
        end else if (phase == PREP) begin
            step_q <= '0;
        end else if (phase == RUN) begin
            step_q <= step_q + 1'b1;
        end
    end

    // all ones means this is the final bit step
    assign last = (phase == RUN) && (&step_q);

endmodule

// ==== md_operand_prep.sv ====
`timescale 1ns/1ns
`include "md_config.svh"

module md_operand_prep
    import md_pkg::*;
(
    input  md_issue_t held,
    output md_prep_t  prep
);

    logic signed_a;
    logic signed_b;
    logic neg_a;
    logic neg_b;
    logic div_zero;
    logic div_ovf;

    always_comb begin
        signed_a    = 1'b0;
        signed_b    = 1'b0;
        prep.is_div = 1'b0;
        prep.sel_hi = 1'b0;
        case (held.op)
            OP_MUL: begin
                prep.sel_hi = 1'b0;
            end
            OP_MULH: begin
                signed_a    = 1'b1;
                signed_b    = 1'b1;
                prep.sel_hi = 1'b1;
            end
            OP_MULHSU: begin
                signed_a    = 1'b1;     // rs2 stays unsigned
                prep.sel_hi = 1'b1;
            end
            OP_MULHU: begin
                prep.sel_hi = 1'b1;
            end
            OP_DIV, OP_REM: begin
                signed_a    = 1'b1;
                signed_b    = 1'b1;
                prep.is_div = 1'b1;
                prep.sel_hi = (held.op == OP_REM);
            end
            default: begin              // DIVU, REMU
                prep.is_div = 1'b1;
                prep.sel_hi = (held.op == OP_REMU);
            end
        endcase

        neg_a = signed_a & held.a[`MD_XLEN-1];
        neg_b = signed_b & held.b[`MD_XLEN-1];

        prep.mag_a = neg_a ? -held.a : held.a;
        prep.mag_b = neg_b ? -held.b : held.b;

        // remainder follows the dividend, everything else the sign product
        prep.negate = (prep.is_div && prep.sel_hi) ? neg_a : (neg_a ^ neg_b);

        div_zero = (held.b == '0);
        div_ovf  = signed_a && (held.a == {1'b1, {(`MD_XLEN-1){1'b0}}}) && (&held.b);

        prep.special = prep.is_div && (div_zero || div_ovf);
        if (div_zero) begin
            prep.special_val = prep.sel_hi ? held.a : '1;
        end else begin
            prep.special_val = prep.sel_hi ? '0 : held.a;   // most negative by -1
        end
    end

endmodule

// ==== md_datapath.sv ====
`timescale 1ns/1ns
`include "md_config.svh"

module md_datapath
    import md_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       busy,
    input  md_issue_t  issue,
    input  md_phase_e  phase,
    input  md_prep_t   prep,
    output md_issue_t  held,
    output md_result_t result
);

    logic [2*`MD_XLEN-1:0] prod_q;      // {upper partial sum, multiplier bits}
    logic [`MD_XLEN-1:0]   rem_q;
    logic [`MD_XLEN-1:0]   quo_q;

    logic [`MD_XLEN:0]     add_sum;
    logic [`MD_XLEN:0]     rem_shift;
    logic [`MD_XLEN:0]     rem_diff;
    logic [2*`MD_XLEN-1:0] prod_fix;
    logic [`MD_XLEN-1:0]   mul_sel;
    logic [`MD_XLEN-1:0]   div_pick;
    logic [`MD_XLEN-1:0]   div_sel;
    logic [`MD_XLEN-1:0]   fix_data;

    // held stays stable for the whole operation, prep is derived from it
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            held <= issue;
        end
    end

    always_comb begin
        // shift-add step, adds multiplicand when the low bit is set
        add_sum = {1'b0, prod_q[2*`MD_XLEN-1:`MD_XLEN]}
                + (prod_q[0] ? {1'b0, prep.mag_a} : {(`MD_XLEN+1){1'b0}});

        // restoring divide step
        rem_shift = {rem_q, quo_q[`MD_XLEN-1]};
        rem_diff  = rem_shift - {1'b0, prep.mag_b};

        prod_fix = prep.negate ? -prod_q : prod_q;
        mul_sel  = prep.sel_hi ? prod_fix[2*`MD_XLEN-1:`MD_XLEN] : prod_fix[`MD_XLEN-1:0];

        div_pick = prep.sel_hi ? rem_q : quo_q;
        div_sel  = prep.negate ? -div_pick : div_pick;

        if (prep.special) begin
            fix_data = prep.special_val;
        end else if (prep.is_div) begin
            fix_data = div_sel;
        end else begin
            fix_data = mul_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PREP) begin
            prod_q <= {{`MD_XLEN{1'b0}}, prep.mag_b};
            rem_q  <= '0;
            quo_q  <= prep.mag_a;           // dividend shifts out as quotient shifts in
        end else if (phase == RUN) begin
            if (prep.is_div) begin
                // borrow means the divisor did not fit, keep the shifted remainder
                if (rem_diff[`MD_XLEN]) begin
                    rem_q <= rem_shift[`MD_XLEN-1:0];
                end else begin
                    rem_q <= rem_diff[`MD_XLEN-1:0];
                end
                quo_q <= {quo_q[`MD_XLEN-2:0], ~rem_diff[`MD_XLEN]};
            end else begin
                prod_q <= {add_sum, prod_q[`MD_XLEN-1:1]};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (phase == FIX) begin
            result.data     <= fix_data;
            result.phy      <= held.phy;
            result.inst_num <= held.inst_num;
        end
    end

endmodule

// ==== md_unit.sv ====
`timescale 1ns/1ns
`include "md_config.svh"

module md_unit
    import md_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  md_issue_t  issue,
    input  logic       flush,
    output logic       busy,
    output logic       done,
    output md_result_t result
);

    md_phase_e phase;
    logic      last;
    md_issue_t held;
    md_prep_t  prep;

    md_control u_control (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .flush (flush),
        .last  (last),
        .phase (phase),
        .busy  (busy),
        .done  (done)
    );

    md_step_counter u_step_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .phase (phase),
        .last  (last)
    );

    // sign handling on the captured op
    md_operand_prep u_operand_prep (
        .held (held),
        .prep (prep)
    );

    md_datapath u_datapath (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .busy   (busy),
        .issue  (issue),
        .phase  (phase),
        .prep   (prep),
        .held   (held),
        .result (result)
    );

endmodule

// ==== md_ref_model.svh ====
`ifndef MD_REF_MODEL_SVH
`define MD_REF_MODEL_SVH

// expected data for one M op, worked out on double-width values
function automatic logic [`MD_XLEN-1:0] ref_result(
    input md_op_e              op,
    input logic [`MD_XLEN-1:0] a,
    input logic [`MD_XLEN-1:0] b
);
    logic signed [2*`MD_XLEN-1:0] sa;
    logic signed [2*`MD_XLEN-1:0] sb;
    logic [2*`MD_XLEN-1:0]        za;
    logic signed [2*`MD_XLEN-1:0] zb;       // zero extended but kept signed for MULHSU
    logic signed [2*`MD_XLEN-1:0] quo_s;
    logic signed [2*`MD_XLEN-1:0] rem_s;
    logic [2*`MD_XLEN-1:0]        wide;
    logic                         ovf;
    logic                         by_zero;

    sa      = {{`MD_XLEN{a[`MD_XLEN-1]}}, a};
    sb      = {{`MD_XLEN{b[`MD_XLEN-1]}}, b};
    za      = {{`MD_XLEN{1'b0}}, a};
    zb      = {{`MD_XLEN{1'b0}}, b};
    ovf     = (a == {1'b1, {(`MD_XLEN-1){1'b0}}}) && (b == '1);
    by_zero = (b == '0);
    wide    = '0;

    // signed divide kept apart so the selects below stay out of its context
    quo_s = sa / sb;
    rem_s = sa % sb;

    case (op)
        OP_MUL:    wide = sa * sb;
        OP_MULH:   wide = (sa * sb) >> `MD_XLEN;
        OP_MULHSU: wide = (sa * zb) >> `MD_XLEN;
        OP_MULHU:  wide = (za * zb) >> `MD_XLEN;
        OP_DIV:    wide = by_zero ? '1 : (ovf ? za : quo_s);
        OP_DIVU:   wide = by_zero ? '1 : za / zb;
        OP_REM:    wide = by_zero ? za : (ovf ? '0 : rem_s);
        OP_REMU:   wide = by_zero ? za : za % zb;
        default:   wide = '0;
    endcase

    // low word is the answer for every op
    return wide[`MD_XLEN-1:0];
endfunction

`endif

// ==== md_unit_tb.sv ====
`timescale 1ns/1ns
`include "md_config.svh"

module md_unit_tb
    import md_pkg::*;
();

    localparam int N_DIRECTED  = 22;
    localparam int N_RANDOM    = 40;
    localparam int N_ENTRIES   = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_NS = (N_ENTRIES + 4) * (`MD_LATENCY + 5) * 20;
    localparam int POKE_ENTRY  = 3;     // second start fired into this one
    localparam int FLUSH_ENTRY = 10;

    typedef struct packed {
        md_op_e                op;
        logic [`MD_XLEN-1:0]   a;
        logic [`MD_XLEN-1:0]   b;
        logic [`MD_PHY_W-1:0]  phy;
        logic [`MD_XLEN-1:0]   exp_data;
    } vec_t;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       flush;
    md_issue_t  issue;
    logic       busy;
    logic       done;
    md_result_t result;

    vec_t vec_table [N_ENTRIES];
    int   n_vec;

    `include "md_ref_model.svh"

    md_unit dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .issue  (issue),
        .flush  (flush),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_vec(input md_op_e op, input logic [`MD_XLEN-1:0] a,
                           input logic [`MD_XLEN-1:0] b, input logic [`MD_PHY_W-1:0] phy);
        vec_table[n_vec] = '{op, a, b, phy, ref_result(op, a, b)};
        n_vec++;
    endtask

    function automatic md_issue_t make_issue(input vec_t v, input int idx);
        md_issue_t iss;
        iss.op       = v.op;
        iss.a        = v.a;
        iss.b        = v.b;
        iss.phy      = v.phy;
        iss.inst_num = 32'h1000 + idx;
        return iss;
    endfunction

    // called at a falling edge with the unit idle, returns one cycle after done
    task automatic check_op(input md_issue_t iss, input logic [`MD_XLEN-1:0] exp_data,
                            input bit poke);
        int        cycles;
        md_issue_t other;
        other          = iss;
        other.a        = iss.a + 1;
        other.phy      = ~iss.phy;
        other.inst_num = ~iss.inst_num;
        start  = 1'b1;
        issue  = iss;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            start = 1'b0;
            if (poke && cycles == 10) begin
                start = 1'b1;
                issue = other;
            end
            if (!done) begin
                assert (busy === 1'b1)
                    else stop_with_failure($sformatf("FAILED busy: got %h expected 1", busy));
                if (cycles > `MD_LATENCY + 5) begin
                    stop_with_failure("done never arrived for an accepted operation");
                end
            end
        end while (!done);

        assert (cycles == `MD_LATENCY)
            else stop_with_failure($sformatf("FAILED done latency: got %h expected %h",
                                             cycles, `MD_LATENCY));
        assert (result.data === exp_data)
            else stop_with_failure($sformatf(
                "FAILED result.data: got %h expected %h (op %h a %h b %h)",
                result.data, exp_data, iss.op, iss.a, iss.b));
        assert (result.phy === iss.phy)
            else stop_with_failure($sformatf("FAILED result.phy: got %h expected %h",
                                             result.phy, iss.phy));
        assert (result.inst_num === iss.inst_num)
            else stop_with_failure($sformatf("FAILED result.inst_num: got %h expected %h",
                                             result.inst_num, iss.inst_num));
        @(negedge clk);
        assert (done === 1'b0)
            else stop_with_failure($sformatf("FAILED done: got %h expected 0", done));
        if (poke) begin
            repeat (`MD_LATENCY + 5) begin
                @(negedge clk);
                assert (done === 1'b0 && busy === 1'b0)
                    else stop_with_failure($sformatf(
                        "FAILED busy, done after ignored start: got %h %h expected 0 0",
                        busy, done));
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("run timed out before all operations finished");
    end

    initial begin
        logic [31:0] seed;
        logic [31:0] ra;
        logic [31:0] rb;
        md_issue_t   iss;

        rst_n      = 1'b0;
        start      = 1'b0;
        flush      = 1'b0;
        issue      = '0;
        n_vec      = 0;

        add_vec(OP_MUL,    32'h0000_0007, 32'h0000_0006, 8'h01);
        add_vec(OP_MUL,    32'hffff_fffd, 32'h0000_0005, 8'h02);
        add_vec(OP_MUL,    32'h8000_0000, 32'hffff_ffff, 8'h03);
        add_vec(OP_MULH,   32'hffff_ffff, 32'hffff_ffff, 8'h04);
        add_vec(OP_MULH,   32'h8000_0000, 32'h8000_0000, 8'h05);
        add_vec(OP_MULH,   32'h7fff_ffff, 32'h8000_0000, 8'h06);
        add_vec(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 8'h07);
        add_vec(OP_MULHSU, 32'h1234_5678, 32'h9abc_def0, 8'h08);
        add_vec(OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 8'h09);
        add_vec(OP_MULHU,  32'h0000_0000, 32'h0001_2345, 8'h0a);
        add_vec(OP_DIV,    32'h0000_0014, 32'hffff_fffd, 8'h0b);
        add_vec(OP_DIV,    32'hffff_ffec, 32'h0000_0003, 8'h0c);
        add_vec(OP_DIV,    32'h0000_1234, 32'h0000_0000, 8'h0d);   // divide by zero
        add_vec(OP_DIV,    32'h8000_0000, 32'hffff_ffff, 8'h0e);   // overflow
        add_vec(OP_DIVU,   32'hffff_ffff, 32'h0000_0003, 8'h0f);
        add_vec(OP_DIVU,   32'h0000_0005, 32'h0000_0000, 8'h10);
        add_vec(OP_REM,    32'hffff_ffec, 32'h0000_0003, 8'h11);
        add_vec(OP_REM,    32'h0000_0014, 32'hffff_fffd, 8'h12);
        add_vec(OP_REM,    32'h8000_0000, 32'hffff_ffff, 8'h13);
        add_vec(OP_REM,    32'h0000_0007, 32'h0000_0000, 8'h14);
        add_vec(OP_REMU,   32'hffff_ffff, 32'h0000_000a, 8'h15);
        add_vec(OP_REMU,   32'h0000_0009, 32'h0000_0000, 8'h16);

        seed = 32'hf9aa;
        for (int i = 0; i < N_RANDOM; i++) begin
            seed = xorshift32(seed);
            ra   = seed;
            seed = xorshift32(seed);
            rb   = seed;
            seed = xorshift32(seed);
            if (seed[3:2] == 2'b00) begin
                rb = rb >> seed[8:4];   // smaller divisors now and then
            end
            add_vec(md_op_e'(seed[2:0]), ra, rb, seed[15:8]);
        end

        repeat (5) @(negedge clk);
        assert (busy === 1'b0 && done === 1'b0)
            else stop_with_failure($sformatf(
                "FAILED busy, done during reset: got %h %h expected 0 0", busy, done));
        rst_n = 1'b1;
        @(negedge clk);
        assert (busy === 1'b0 && done === 1'b0)
            else stop_with_failure($sformatf(
                "FAILED busy, done after reset: got %h %h expected 0 0", busy, done));
        assert (result === '0)
            else stop_with_failure($sformatf("FAILED result after reset: got %h expected 0",
                                             result));

        for (int i = 0; i < n_vec; i++) begin
            check_op(make_issue(vec_table[i], i), vec_table[i].exp_data, i == POKE_ENTRY);
        end

        // kill an operation halfway and make sure it stays dead
        start = 1'b1;
        issue = make_issue(vec_table[1], 100);
        @(negedge clk);
        start = 1'b0;
        repeat (11) @(negedge clk);
        assert (busy === 1'b1)
            else stop_with_failure($sformatf("FAILED busy before flush: got %h expected 1", busy));
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        assert (busy === 1'b0 && done === 1'b0)
            else stop_with_failure($sformatf(
                "FAILED busy, done after flush: got %h %h expected 0 0", busy, done));
        repeat (`MD_LATENCY + 5) begin
            @(negedge clk);
            assert (done === 1'b0)
                else stop_with_failure($sformatf("FAILED done after flush: got %h expected 0",
                                                 done));
        end

        iss     = make_issue(vec_table[FLUSH_ENTRY], 200);
        iss.phy = 8'hee;
        check_op(iss, vec_table[FLUSH_ENTRY].exp_data, 1'b0);

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
md_pkg.sv
md_control.sv
md_step_counter.sv
md_operand_prep.sv
md_datapath.sv
md_unit.sv
md_unit_tb.sv
